// ==== filelist.f ====
verilog/mem_pkg.sv
verilog/op_pkg.sv
verilog/align_instructions.sv
verilog/pc_gen.sv
verilog/l0_icache.sv
verilog/fetch.sv
verilog/frontend_top.sv
tests/frontend_properties.sv
tests/frontend_tb.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  - verilog/mem_pkg.sv
  - verilog/op_pkg.sv
  - verilog/align_instructions.sv
  - verilog/pc_gen.sv
  - verilog/l0_icache.sv
  - verilog/fetch.sv
  - verilog/frontend_top.sv
  - target: test
    files:
      - tests/frontend_properties.sv
      - tests/frontend_tb.sv

// ==== tests/frontend_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontend_tb;
  import mem_pkg::*;
  import op_pkg::*;

  localparam int SUPER_SCALAR_WIDTH = SUPER_SCALAR_WIDTH_DEFAULT;
  localparam int L0_ENTRIES         = 8;
  localparam int INDEX_BITS         = $clog2(L0_ENTRIES);
  localparam int LINE_WORDS         = LINE_BYTES / INSTR_BYTES;
  localparam int NUM_BUNDLES        = 3000;
  // stale response, fresh miss and a back-pressure stretch in the worst case
  localparam int CYCLES_PER_BUNDLE  = 24;
  localparam int MAX_CYCLES         = NUM_BUNDLES * CYCLES_PER_BUNDLE;

  logic          clk_in = 1'b0;
  logic          rst_N_in;
  logic          flush_in;
  addr_t         redirect_pc;
  l1i_req_t      l1i_req;
  logic          l1i_valid;
  cacheline_t    l1i_cacheline;
  logic          decode_ready;
  fetch_bundle_t bundle;
  logic          fetch_valid;

  logic [31:0] hash_key;               // makes memory contents depend on the seed
  addr_t       exp_pc;                 // pc of the next bundle decode should take
  int          consumed;
  int          cycles;
  int          resp_wait;              // cycles until the L1I answers, 0 when idle
  addr_t       resp_addr;
  addr_t       l0_lines  [L0_ENTRIES]; // lines the L0 must hold by now
  logic        l0_filled [L0_ENTRIES];

  frontend_top #(
    .SUPER_SCALAR_WIDTH(SUPER_SCALAR_WIDTH),
    .L0_ENTRIES        (L0_ENTRIES)
  ) u_frontend_top (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .flush_in     (flush_in),
    .redirect_pc  (redirect_pc),
    .l1i_req      (l1i_req),
    .l1i_valid    (l1i_valid),
    .l1i_cacheline(l1i_cacheline),
    .decode_ready (decode_ready),
    .bundle       (bundle),
    .fetch_valid  (fetch_valid)
  );

  bind frontend_top frontend_properties u_frontend_properties (
    .clk_in      (clk_in),
    .rst_N_in    (rst_N_in),
    .flush_in    (flush_in),
    .decode_ready(decode_ready),
    .fetch_valid (fetch_valid),
    .bundle      (bundle),
    .l1i_req     (l1i_req),
    .l1i_valid   (l1i_valid)
  );

  always #20 clk_in = ~clk_in;

  // memory word at a byte address, a hash of the address
  function automatic instr_t mem_word(input addr_t addr);
    logic [31:0] h;
    h = addr[31:0] ^ (addr[63:32] * 32'h27d4eb2d) ^ hash_key;
    h = (h ^ (h >> 16)) * 32'h7feb352d;
    h = (h ^ (h >> 15)) * 32'h846ca68b;
    return h ^ (h >> 16);
  endfunction

  function automatic cacheline_t line_data(input addr_t line);
    cacheline_t data;
    for (int j = 0; j < LINE_WORDS; j++) begin
      data[j*INSTRUCTION_WIDTH +: INSTRUCTION_WIDTH] = mem_word(line + addr_t'(j * INSTR_BYTES));
    end
    return data;
  endfunction

  // step by the slots that stay inside the line
  function automatic addr_t next_fetch_pc(input addr_t pc);
    int words_left;
    int slots;
    words_left = LINE_WORDS - int'(pc[OFFSET_BITS-1:INSTR_ALIGN_BITS]);
    slots      = (words_left < SUPER_SCALAR_WIDTH) ? words_left : SUPER_SCALAR_WIDTH;
    return pc + addr_t'(slots * INSTR_BYTES);
  endfunction

  function automatic addr_t flush_target();
    addr_t target;
    target = addr_t'($urandom % 512) << INSTR_ALIGN_BITS;  // 2 KB window so lines come back
    if ($urandom % 4 == 0) begin
      target[OFFSET_BITS-1:0] = OFFSET_BITS'(LINE_BYTES - INSTR_BYTES * (1 + $urandom % 3));
    end
    if ($urandom % 8 == 0) begin
      target[63:32] = $urandom;  // far target, other tag
    end
    return target;
  endfunction

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_instr(input instr_t got, input instr_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_assertions();
    if (u_frontend_top.u_frontend_properties.fail_count != 0) begin
      stop_on_failure("a bound assertion on the front end outputs failed");
    end
  endtask

  task automatic check_bundle();
    int     first;
    instr_t exp;
    compare_addr(bundle.pc, exp_pc, $sformatf("pc of bundle %0d", consumed));
    first = int'(exp_pc[OFFSET_BITS-1:INSTR_ALIGN_BITS]);
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      exp = (first + i < LINE_WORDS) ? mem_word(exp_pc + addr_t'(i * INSTR_BYTES)) : NOP_INSTR;
      compare_instr(bundle.slots[i], exp, $sformatf("slot %0d of bundle at %h", i, exp_pc));
    end
    exp_pc = next_fetch_pc(exp_pc);
    consumed++;
  endtask

  // L1I answers each request once, 1 to 6 cycles later
  task automatic l1i_model();
    int idx;
    l1i_valid <= 1'b0;
    if (l1i_req.valid) begin
      idx = int'(l1i_req.addr[OFFSET_BITS +: INDEX_BITS]);
      if (resp_wait != 0) begin
        stop_on_failure("L1I request issued while another response was outstanding");
      end
      if (l0_filled[idx] && l0_lines[idx] == l1i_req.addr) begin
        stop_on_failure($sformatf("line %h requested again while held in the L0", l1i_req.addr));
      end
    end
    if (resp_wait != 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        idx            = int'(resp_addr[OFFSET_BITS +: INDEX_BITS]);
        l1i_valid     <= 1'b1;
        l1i_cacheline <= line_data(resp_addr);
        l0_lines[idx]  = resp_addr;  // every response fills, stale or not
        l0_filled[idx] = 1'b1;
      end
    end
    if (l1i_req.valid) begin
      resp_addr = l1i_req.addr;
      resp_wait = 1 + int'($urandom % 6);
    end
  endtask

  task automatic drive_inputs();
    decode_ready <= ($urandom % 4) != 0;  // low about a quarter of the time
    if ($urandom % 40 == 0) begin
      flush_in    <= 1'b1;
      redirect_pc <= flush_target();
    end else begin
      flush_in <= 1'b0;
    end
  endtask

  initial begin
    void'($urandom(32'h92bfa17e));
    hash_key      = $urandom;
    rst_N_in      = 1'b1;
    flush_in      = 1'b0;
    redirect_pc   = '0;
    l1i_valid     = 1'b0;
    l1i_cacheline = '0;
    decode_ready  = 1'b0;
    exp_pc        = '0;  // first bundle after reset starts at zero
    consumed      = 0;
    cycles        = 0;
    resp_wait     = 0;
    resp_addr     = '0;
    l0_lines      = '{default: '0};
    l0_filled     = '{default: 1'b0};

    for (int i = 0; i < 8; i++) begin
      @(posedge clk_in);
      if (i > 0 && (fetch_valid !== 1'b0 || l1i_req.valid !== 1'b0)) begin
        stop_on_failure("fetch_valid or the L1I request was not low during reset");
      end
    end
    rst_N_in <= 1'b0;

    while (consumed < NUM_BUNDLES) begin
      @(posedge clk_in);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        stop_on_failure($sformatf("timeout: only %0d of %0d bundles arrived in %0d cycles",
                                  consumed, NUM_BUNDLES, cycles));
      end
      check_assertions();
      if (fetch_valid && decode_ready) begin
        check_bundle();
      end
      if (flush_in) begin
        exp_pc = redirect_pc;  // stream restarts at the target
      end
      l1i_model();
      drive_inputs();
    end

    @(negedge clk_in);
    if (u_frontend_top.u_frontend_properties.fail_count != 0) begin
      stop_on_failure("a bound assertion on the front end outputs failed");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/frontend_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontend_properties (
  input logic                  clk_in,
  input logic                  rst_N_in,
  input logic                  flush_in,
  input logic                  decode_ready,
  input logic                  fetch_valid,
  input op_pkg::fetch_bundle_t bundle,
  input mem_pkg::l1i_req_t     l1i_req,
  input logic                  l1i_valid
);
  logic outstanding;     // request sent, response not back yet
  int   fail_count = 0;  // assertions that have failed so far

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      outstanding <= 1'b0;
    end else begin
      outstanding <= l1i_req.valid | (outstanding & ~l1i_valid);
    end
  end

  a_flush_drops_valid : assert property (@(posedge clk_in) disable iff (rst_N_in)
    flush_in |=> !fetch_valid)
    else begin
      $error("fetch_valid high in the cycle after a flush");
      fail_count++;
    end

  a_req_one_cycle : assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req.valid |=> !l1i_req.valid)
    else begin
      $error("l1i_req valid high for two cycles in a row");
      fail_count++;
    end

  // held bundle must not move while decode stalls
  a_hold_on_stall : assert property (@(posedge clk_in) disable iff (rst_N_in)
    fetch_valid && !decode_ready && !flush_in |=> $stable(fetch_valid) && $stable(bundle))
    else begin
      $error("bundle changed while decode_ready was low");
      fail_count++;
    end

  a_one_miss : assert property (@(posedge clk_in) disable iff (rst_N_in)
    outstanding |-> !l1i_req.valid)
    else begin
      $error("l1i_req issued while a response was outstanding");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== verilog/frontend_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontend_top #(
  parameter int SUPER_SCALAR_WIDTH = op_pkg::SUPER_SCALAR_WIDTH_DEFAULT,
  parameter int L0_ENTRIES         = 8
) (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  flush_in,
  input  mem_pkg::addr_t        redirect_pc,
  output mem_pkg::l1i_req_t     l1i_req,
  input  logic                  l1i_valid,
  input  mem_pkg::cacheline_t   l1i_cacheline,
  input  logic                  decode_ready,
  output op_pkg::fetch_bundle_t bundle,
  output logic                  fetch_valid
);
  import mem_pkg::*;

  addr_t      pc;
  logic       pc_valid;
  logic       miss_pending;
  cacheline_t l0_line;
  logic       l0_valid;
  logic       fetch_ready;

  pc_gen #(
    .SUPER_SCALAR_WIDTH(SUPER_SCALAR_WIDTH)
  ) u_pc_gen (
    .clk_in      (clk_in),
    .rst_N_in    (rst_N_in),
    .flush_in    (flush_in),
    .redirect_pc (redirect_pc),
    .fetch_ready (fetch_ready),
    .miss_pending(miss_pending),
    .pc          (pc),
    .pc_valid    (pc_valid)
  );

  l0_icache #(
    .L0_ENTRIES(L0_ENTRIES)
  ) u_l0_icache (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .flush_in     (flush_in),
    .pc           (pc),
    .pc_valid     (pc_valid),
    .l1i_valid    (l1i_valid),
    .l1i_cacheline(l1i_cacheline),
    .l0_line      (l0_line),
    .l0_valid     (l0_valid),
    .l1i_req      (l1i_req),
    .miss_pending (miss_pending)
  );

  fetch #(
    .SUPER_SCALAR_WIDTH(SUPER_SCALAR_WIDTH)
  ) u_fetch (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .flush_in     (flush_in),
    .pc           (pc),
    .pc_valid     (pc_valid),
    .l0_line      (l0_line),
    .l0_valid     (l0_valid),
    .l1i_cacheline(l1i_cacheline),
    .l1i_valid    (l1i_valid),
    .decode_ready (decode_ready),
    .bundle       (bundle),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready)
  );

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch #(
  parameter int SUPER_SCALAR_WIDTH = op_pkg::SUPER_SCALAR_WIDTH_DEFAULT
) (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  flush_in,
  input  mem_pkg::addr_t        pc,
  input  logic                  pc_valid,
  input  mem_pkg::cacheline_t   l0_line,
  input  logic                  l0_valid,
  input  mem_pkg::cacheline_t   l1i_cacheline,
  input  logic                  l1i_valid,
  input  logic                  decode_ready,  // level, decode takes the bundle
  output op_pkg::fetch_bundle_t bundle,
  output logic                  fetch_valid,
  output logic                  fetch_ready
);
  import op_pkg::*;
  import mem_pkg::*;

  instr_t l0_instrs  [SUPER_SCALAR_WIDTH];
  instr_t l1i_instrs [SUPER_SCALAR_WIDTH];

  logic l1i_waiting;       // a miss for this stream is at the L1I
  logic l1i_waiting_next;
  logic discard_l1i;       // next response belongs to a flushed path
  logic discard_l1i_next;
  logic use_l1i;
  logic served;            // a bundle for pc is built this cycle

  fetch_bundle_t next_bundle;
  fetch_bundle_t skid_bundle;
  logic          skid_valid;

  // the bundle struct is sized by the package default
  if (SUPER_SCALAR_WIDTH != SUPER_SCALAR_WIDTH_DEFAULT) begin : g_width_check
    $error("fetch: SUPER_SCALAR_WIDTH must equal op_pkg::SUPER_SCALAR_WIDTH_DEFAULT");
  end

  align_instructions #(
    .SUPER_SCALAR_WIDTH(SUPER_SCALAR_WIDTH)
  ) l0_align (
    .offset   (line_offset(pc)),
    .cacheline(l0_line),
    .instr_out(l0_instrs)
  );

  align_instructions #(
    .SUPER_SCALAR_WIDTH(SUPER_SCALAR_WIDTH)
  ) l1i_align (
    .offset   (line_offset(pc)),
    .cacheline(l1i_cacheline),
    .instr_out(l1i_instrs)
  );

  // mirrors the miss tracking in the L0 so both agree on a stale response
  assign use_l1i          = pc_valid & l1i_valid & l1i_waiting & ~discard_l1i;
  assign served           = pc_valid & (l0_valid | use_l1i);
  assign l1i_waiting_next = (pc_valid & ~l0_valid & ~l1i_waiting) | (l1i_waiting & ~l1i_valid);
  assign discard_l1i_next = flush_in ? (l1i_waiting & ~l1i_valid) : (discard_l1i & ~l1i_valid);

  // returning line wins over the L0 copy
  always_comb begin
    next_bundle.pc = pc;
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      next_bundle.slots[i] = use_l1i ? l1i_instrs[i] : l0_instrs[i];
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      fetch_valid <= 1'b0;
      fetch_ready <= 1'b0;
      skid_valid  <= 1'b0;
      l1i_waiting <= 1'b0;
      discard_l1i <= 1'b0;
    end else begin
      fetch_ready <= decode_ready;  // pc_gen sees back-pressure one cycle late
      l1i_waiting <= l1i_waiting_next;
      discard_l1i <= discard_l1i_next;
      if (flush_in) begin
        fetch_valid <= 1'b0;
      end else if (decode_ready) begin
        fetch_valid <= skid_valid | served;
      end
      // skid catches the pc issued in the cycle decode_ready dropped
      if (flush_in || decode_ready) begin
        skid_valid <= 1'b0;
      end else if (served) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (flush_in) begin
      bundle <= '0;
    end else if (decode_ready) begin
      bundle <= skid_valid ? skid_bundle : next_bundle;
    end
    if (!decode_ready && served) begin
      skid_bundle <= next_bundle;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/l0_icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module l0_icache #(
  parameter int L0_ENTRIES = 8
) (
  input  logic                clk_in,
  input  logic                rst_N_in,
  input  logic                flush_in,
  input  mem_pkg::addr_t      pc,
  input  logic                pc_valid,
  input  logic                l1i_valid,      // one-cycle response pulse
  input  mem_pkg::cacheline_t l1i_cacheline,
  output mem_pkg::cacheline_t l0_line,
  output logic                l0_valid,       // hit for pc this cycle
  output mem_pkg::l1i_req_t   l1i_req,
  output logic                miss_pending    // pc cannot be served this cycle
);
  import mem_pkg::*;

  localparam int INDEX_BITS = $clog2(L0_ENTRIES);
  localparam int TAG_BITS   = ADDR_WIDTH - OFFSET_BITS - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  tag_t                  tag_q  [L0_ENTRIES];
  cacheline_t            line_q [L0_ENTRIES];
  logic [L0_ENTRIES-1:0] valid_q;

  index_t pc_index;
  tag_t   pc_tag;
  index_t fill_index;
  tag_t   fill_tag;

  logic  req_valid_q;
  addr_t req_addr_q;  // line of the outstanding miss, kept across a flush
  logic  pend_q;      // one miss outstanding at the L1I
  logic  stale_q;     // outstanding miss was issued before a flush
  logic  issue;
  logic  accept_fill;
  logic  fill_now;

  if (L0_ENTRIES < 2 || (L0_ENTRIES & (L0_ENTRIES - 1)) != 0) begin : g_entries_check
    $error("l0_icache: L0_ENTRIES must be a power of two and at least 2");
  end

  // direct mapped, index right above the line offset
  assign pc_index   = pc[OFFSET_BITS +: INDEX_BITS];
  assign pc_tag     = pc[ADDR_WIDTH-1 -: TAG_BITS];
  assign fill_index = req_addr_q[OFFSET_BITS +: INDEX_BITS];
  assign fill_tag   = req_addr_q[ADDR_WIDTH-1 -: TAG_BITS];

  assign l0_line  = line_q[pc_index];
  assign l0_valid = pc_valid & valid_q[pc_index] & (tag_q[pc_index] == pc_tag);

  assign accept_fill = l1i_valid & pend_q;
  assign fill_now    = accept_fill & ~stale_q;  // response is for the pc being fetched

  // a second miss waits until the first response is back
  assign issue        = pc_valid & ~l0_valid & ~pend_q;
  assign miss_pending = pc_valid & ~l0_valid & ~fill_now;

  assign l1i_req = '{valid: req_valid_q, addr: req_addr_q};

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      valid_q     <= '0;
      req_valid_q <= 1'b0;
      pend_q      <= 1'b0;
      stale_q     <= 1'b0;
    end else begin
      req_valid_q <= issue;  // single-cycle strobe
      pend_q      <= issue | (pend_q & ~l1i_valid);
      // a flush marks the outstanding miss, its response only fills the array
      stale_q     <= flush_in ? (pend_q & ~l1i_valid) : (stale_q & ~l1i_valid);
      if (accept_fill) begin
        valid_q[fill_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (issue) begin
      req_addr_q <= line_addr(pc);
    end
    if (accept_fill) begin
      tag_q[fill_index]  <= fill_tag;
      line_q[fill_index] <= l1i_cacheline;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pc_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_gen #(
  parameter int SUPER_SCALAR_WIDTH = op_pkg::SUPER_SCALAR_WIDTH_DEFAULT
) (
  input  logic           clk_in,
  input  logic           rst_N_in,
  input  logic           flush_in,     // redirect from the back end
  input  mem_pkg::addr_t redirect_pc,
  input  logic           fetch_ready,
  input  logic           miss_pending,  // current pc waits on the L1I
  output mem_pkg::addr_t pc,
  output logic           pc_valid
);
  import op_pkg::*;
  import mem_pkg::*;

  localparam int LINE_WORDS = LINE_BYTES / INSTR_BYTES;
  localparam int CNT_BITS   = OFFSET_BITS - INSTR_ALIGN_BITS + 1;

  // counts instruction words, wide enough to hold LINE_WORDS
  typedef logic [CNT_BITS-1:0] count_t;

  addr_t  pc_q;
  logic   valid_q;
  count_t words_left;  // words from pc to the end of its line
  count_t slots;       // slots of this bundle that lie inside the line
  addr_t  step;
  logic   advance;

  assign words_left = count_t'(LINE_WORDS) - count_t'(pc_q[OFFSET_BITS-1:INSTR_ALIGN_BITS]);
  assign slots      = (words_left < count_t'(SUPER_SCALAR_WIDTH)) ?
                      words_left : count_t'(SUPER_SCALAR_WIDTH);
  assign step       = addr_t'(slots) << INSTR_ALIGN_BITS;

  // nothing goes out while fetch is back-pressured or in the flush cycle
  assign pc       = pc_q;
  assign pc_valid = valid_q & fetch_ready & ~flush_in;
  assign advance  = pc_valid & ~miss_pending;  // fetch took this pc

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else if (flush_in) begin
      pc_q    <= redirect_pc;  // issued the next cycle
      valid_q <= 1'b1;
    end else begin
      valid_q <= 1'b1;
      if (advance) begin
        pc_q <= pc_q + step;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/align_instructions.sv ====
`timescale 1ns/100ps
`default_nettype none

module align_instructions #(
  parameter int SUPER_SCALAR_WIDTH = op_pkg::SUPER_SCALAR_WIDTH_DEFAULT
) (
  input  logic [mem_pkg::OFFSET_BITS-1:0] offset,     // byte offset of the first slot
  input  mem_pkg::cacheline_t             cacheline,
  output op_pkg::instr_t                  instr_out [SUPER_SCALAR_WIDTH]
);
  import op_pkg::*;
  import mem_pkg::*;

  localparam int LINE_WORDS    = LINE_BYTES / INSTR_BYTES;
  localparam int WORD_SEL_BITS = OFFSET_BITS - INSTR_ALIGN_BITS;

  // one extra bit to see a slot run past the line end
  typedef logic [WORD_SEL_BITS:0] word_idx_t;

  logic [WORD_SEL_BITS-1:0] first_word;

  assign first_word = offset[OFFSET_BITS-1:INSTR_ALIGN_BITS];  // word index, not byte

  for (genvar i = 0; i < SUPER_SCALAR_WIDTH; i++) begin : g_slot
    word_idx_t word_idx;
    logic      in_line;

    assign word_idx     = word_idx_t'(first_word) + word_idx_t'(i);
    assign in_line      = word_idx < word_idx_t'(LINE_WORDS);
    assign instr_out[i] = in_line ?
        cacheline[word_idx[WORD_SEL_BITS-1:0] * INSTRUCTION_WIDTH +: INSTRUCTION_WIDTH] :
        NOP_INSTR;
  end

endmodule

`default_nettype wire

// ==== verilog/op_pkg.sv ====
`default_nettype none

// instruction side of the front end: instruction words and the decode bundle
package op_pkg;

  localparam int INSTRUCTION_WIDTH = 32;
  localparam int INSTR_BYTES       = INSTRUCTION_WIDTH / 8;
  localparam int INSTR_ALIGN_BITS  = $clog2(INSTR_BYTES);  // low PC bits inside a word

  // number of slots handed to decode per cycle
  localparam int SUPER_SCALAR_WIDTH_DEFAULT = 4;

  // one fixed-width instruction
  typedef logic [INSTRUCTION_WIDTH-1:0] instr_t;

  // filler for slots that fall past the end of the line
  localparam instr_t NOP_INSTR = 32'hD503201F;

  // what fetch hands to decode
  // slot 0 holds the word at pc, slot i the word at pc + 4*i
  typedef struct packed {
    mem_pkg::addr_t pc;
    instr_t [0:SUPER_SCALAR_WIDTH_DEFAULT-1] slots;
  } fetch_bundle_t;

endpackage

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

// memory side of the front end: byte addresses, cache lines and the L1I request
package mem_pkg;

  localparam int ADDR_WIDTH = 64;

  // byte address, used for the fetch PC and for line addresses
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // line geometry
  localparam int LINE_BYTES  = 64;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);  // byte offset inside a line
  localparam int LINE_WIDTH  = LINE_BYTES * 8;

  // one cache line, byte 0 sits in bits [7:0]
  typedef logic [LINE_WIDTH-1:0] cacheline_t;

  // request strobe towards the L1I
  typedef struct packed {
    logic  valid;  // one-cycle pulse
    addr_t addr;   // line address, offset bits are zero
  } l1i_req_t;

  // clears the byte offset of an address
  function automatic addr_t line_addr(input addr_t byte_addr);
    addr_t result;
    result = {byte_addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    return result;
  endfunction

  // byte offset of an address inside its line
  function automatic logic [OFFSET_BITS-1:0] line_offset(input addr_t byte_addr);
    logic [OFFSET_BITS-1:0] result;
    result = byte_addr[OFFSET_BITS-1:0];
    return result;
  endfunction

endpackage

`default_nettype wire
